//--- common/fzr_pkg.sv
// shared definitions of the chunk-serial RV32I core
// holds the word and register types, the decode constants and the alu encoding
// modules pull it in with a wildcard import in the body

package fzr_pkg;

  // architectural word width
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  // --------------------------------------------------------------------------
  // instruction fields
  // --------------------------------------------------------------------------

  // major opcodes of the kept instruction classes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // funct3 values, add also covers sub via funct7 bit 5
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_SW  = 3'b010;

  // alu operation handed from decode to execute
  // none marks an instruction that only advances the pc
  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_XOR  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_AND  = 3'd4,
    ALU_NONE = 3'd5
  } alu_op_e;

  // --------------------------------------------------------------------------
  // chunk helpers
  // --------------------------------------------------------------------------

  // width of the counter that walks one word in chunks of chunksize bits
  function automatic int chunk_cnt_w(input int chunksize);
    return $clog2(XLEN / chunksize);
  endfunction

endpackage

//--- hdl/fzr_fetch_decode.sv
// fetch and decode stage of the chunk-serial core
// owns the pc and the instruction bus request, latches the fetched word
// and feeds the execute unit with the decoded operation and a serial immediate

module fzr_fetch_decode #(
  parameter int             CHUNKSIZE = 2,
  parameter fzr_pkg::word_t BOOTADR   = 32'h0000_0000
) (
  input  logic                 clk_i,
  input  logic                 rst_in,
  input  logic                 insn_done_i,

  input  fzr_pkg::word_t       imem_dat_i,
  input  logic                 imem_ack_i,
  output logic                 imem_stb_o,
  output logic                 imem_cyc_o,
  output fzr_pkg::word_t       imem_adr_o,

  output logic                 insn_start_o,
  output fzr_pkg::alu_op_e     alu_op_o,
  output logic                 is_store_o,
  output fzr_pkg::reg_idx_t    rs1_o,
  output fzr_pkg::reg_idx_t    rs2_o,
  output fzr_pkg::reg_idx_t    rd_o,
  output logic                 rd_we_o,
  output logic [CHUNKSIZE-1:0] imm_chunk_o,
  input  logic                 imm_shift_i
);

  import fzr_pkg::*;

  word_t      pc_r;
  logic       stb_r;
  logic       busy_r;
  logic       start_r;
  word_t      ir_r;
  word_t      imm_r;
  word_t      imm_dec;
  logic [6:0] opcode;
  logic [2:0] funct3;

  // --------------------------------------------------------------------------
  // fetch control
  // --------------------------------------------------------------------------

  // one instruction in flight, stb held until ack
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      pc_r    <= BOOTADR;
      stb_r   <= 1'b0;
      busy_r  <= 1'b0;
      start_r <= 1'b0;
    end else begin
      start_r <= 1'b0;
      if (stb_r && imem_ack_i) begin
        // word taken, start execute in the next cycle
        stb_r   <= 1'b0;
        busy_r  <= 1'b1;
        start_r <= 1'b1;
      end else if (busy_r && insn_done_i) begin
        busy_r <= 1'b0;
        pc_r   <= pc_r + 32'd4;
        stb_r  <= 1'b1;
      end else if (!stb_r && !busy_r) begin
        // first fetch after reset
        stb_r <= 1'b1;
      end
    end
  end

  assign imem_stb_o   = stb_r;
  assign imem_cyc_o   = stb_r;
  assign imem_adr_o   = pc_r;
  assign insn_start_o = start_r;

  // --------------------------------------------------------------------------
  // instruction and immediate registers
  // --------------------------------------------------------------------------

  // sign-extended immediate straight off the bus
  // register ops load zero so execute can or it with rs2
  always_comb begin
    case (imem_dat_i[6:0])
      OPC_STORE:  imm_dec = {{20{imem_dat_i[31]}}, imem_dat_i[31:25], imem_dat_i[11:7]};
      OPC_OP_IMM: imm_dec = {{20{imem_dat_i[31]}}, imem_dat_i[31:20]};
      default:    imm_dec = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (stb_r && imem_ack_i) begin
      ir_r  <= imem_dat_i;
      imm_r <= imm_dec;
    end else if (imm_shift_i) begin
      // lsb chunk first, top filled with the sign
      imm_r <= {{CHUNKSIZE{imm_r[XLEN-1]}}, imm_r[XLEN-1:CHUNKSIZE]};
    end
  end

  assign imm_chunk_o = imm_r[CHUNKSIZE-1:0];

  // --------------------------------------------------------------------------
  // decoder
  // --------------------------------------------------------------------------

  assign opcode = ir_r[6:0];
  assign funct3 = ir_r[14:12];
  assign rs1_o  = ir_r[19:15];
  assign rd_o   = ir_r[11:7];

  always_comb begin
    alu_op_o   = ALU_NONE;
    is_store_o = 1'b0;
    rs2_o      = ir_r[24:20];
    case (opcode)
      OPC_OP: begin
        case (funct3)
          F3_ADD:  alu_op_o = ir_r[30] ? ALU_SUB : ALU_ADD;
          F3_XOR:  alu_op_o = ALU_XOR;
          F3_OR:   alu_op_o = ALU_OR;
          F3_AND:  alu_op_o = ALU_AND;
          default: alu_op_o = ALU_NONE;
        endcase
      end
      OPC_OP_IMM: begin
        // rs2 field is immediate here, x0 makes the register operand zero
        rs2_o = '0;
        case (funct3)
          F3_ADD:  alu_op_o = ALU_ADD;
          F3_XOR:  alu_op_o = ALU_XOR;
          F3_OR:   alu_op_o = ALU_OR;
          F3_AND:  alu_op_o = ALU_AND;
          default: alu_op_o = ALU_NONE;
        endcase
      end
      OPC_STORE: begin
        // address is rs1 + imm through the adder
        if (funct3 == F3_SW) begin
          alu_op_o   = ALU_ADD;
          is_store_o = 1'b1;
        end
      end
      default: begin
        alu_op_o = ALU_NONE;
      end
    endcase
  end

  // no write for stores, x0 and anything not decoded
  assign rd_we_o = (alu_op_o != ALU_NONE) && !is_store_o && (rd_o != '0);

endmodule

//--- hdl/fzr_regfile.sv
// register bank of the chunk-serial core
// 31 words accessed one chunk at a time, both read ports share the chunk index
// x0 is not stored and always reads as zero

module fzr_regfile #(
  parameter int CHUNKSIZE = 2
) (
  input  logic                                       clk_i,
  input  logic                                       rst_in,
  input  fzr_pkg::reg_idx_t                          rs1_i,
  input  fzr_pkg::reg_idx_t                          rs2_i,
  input  fzr_pkg::reg_idx_t                          rd_i,
  input  logic [fzr_pkg::chunk_cnt_w(CHUNKSIZE)-1:0] chunk_idx_i,
  input  logic                                       wr_en_i,
  input  logic [CHUNKSIZE-1:0]                       res_chunk_i,
  output logic [CHUNKSIZE-1:0]                       rs1_chunk_o,
  output logic [CHUNKSIZE-1:0]                       rs2_chunk_o
);

  import fzr_pkg::*;

  word_t regs [1:31];
  word_t rs1_word;
  word_t rs2_word;

  // --------------------------------------------------------------------------
  // read side
  // --------------------------------------------------------------------------

  assign rs1_word = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_word = (rs2_i == '0) ? '0 : regs[rs2_i];

  // old value of the current chunk, write lands at the clock edge
  // so rd may alias rs1 or rs2
  assign rs1_chunk_o = rs1_word[chunk_idx_i*CHUNKSIZE +: CHUNKSIZE];
  assign rs2_chunk_o = rs2_word[chunk_idx_i*CHUNKSIZE +: CHUNKSIZE];

  // --------------------------------------------------------------------------
  // write side
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (wr_en_i && (rd_i != '0)) begin
      regs[rd_i][chunk_idx_i*CHUNKSIZE +: CHUNKSIZE] <= res_chunk_i;
    end
  end

  // datapath only works for chunk widths dividing a word in powers of two
  a_chunksize_legal: assert property (
    @(posedge clk_i) CHUNKSIZE inside {1, 2, 4, 8}
  );

  // decode must never request a write to x0
  a_no_x0_write: assert property (
    @(posedge clk_i) disable iff (!rst_in)
    wr_en_i |-> (rd_i != '0)
  );

endmodule

//--- hdl/fzr_execute.sv
// execute unit of the chunk-serial core
// walks one word in chunks through a carry-chained alu and writes back rd
// for stores it collects address and data and runs the data bus request

module fzr_execute #(
  parameter int CHUNKSIZE = 2
) (
  input  logic                                       clk_i,
  input  logic                                       rst_in,

  input  logic                                       insn_start_i,
  input  fzr_pkg::alu_op_e                           alu_op_i,
  input  logic                                       is_store_i,
  input  logic                                       rd_we_i,

  input  logic [CHUNKSIZE-1:0]                       rs1_chunk_i,
  input  logic [CHUNKSIZE-1:0]                       rs2_chunk_i,
  input  logic [CHUNKSIZE-1:0]                       imm_chunk_i,

  output logic [fzr_pkg::chunk_cnt_w(CHUNKSIZE)-1:0] chunk_idx_o,
  output logic                                       wr_en_o,
  output logic [CHUNKSIZE-1:0]                       res_chunk_o,
  output logic                                       imm_shift_o,
  output logic                                       insn_done_o,

  input  logic                                       dmem_ack_i,
  output logic                                       dmem_stb_o,
  output logic                                       dmem_cyc_o,
  output logic                                       dmem_we_o,
  output logic [3:0]                                 dmem_be_o,
  output fzr_pkg::word_t                             dmem_adr_o,
  output fzr_pkg::word_t                             dmem_dat_o
);

  import fzr_pkg::*;

  localparam int CW     = chunk_cnt_w(CHUNKSIZE);
  localparam int NCHUNK = XLEN / CHUNKSIZE;

  logic                 active_r;
  logic [CW-1:0]        cnt_r;
  logic                 carry_r;
  logic                 stb_r;
  word_t                adr_r;
  word_t                dat_r;

  logic                 first_chunk;
  logic                 last_chunk;
  logic                 sub;
  logic                 cin;
  logic [CHUNKSIZE-1:0] op_b;
  logic [CHUNKSIZE-1:0] op_b_inv;
  logic [CHUNKSIZE:0]   sum;

  // --------------------------------------------------------------------------
  // chunk alu
  // --------------------------------------------------------------------------

  assign first_chunk = (cnt_r == '0);
  assign last_chunk  = active_r && (cnt_r == CW'(NCHUNK - 1));
  assign sub         = (alu_op_i == ALU_SUB);

  // decode zeroes the unused source so the or picks rs2 or imm
  // stores add the immediate to rs1 and send rs2 as data
  assign op_b     = is_store_i ? imm_chunk_i : (rs2_chunk_i | imm_chunk_i);
  assign op_b_inv = sub ? ~op_b : op_b;

  // sub is a + ~b + 1 with the +1 entering as carry of chunk 0
  assign cin = first_chunk ? sub : carry_r;
  assign sum = {1'b0, rs1_chunk_i} + {1'b0, op_b_inv} + {{CHUNKSIZE{1'b0}}, cin};

  always_comb begin
    case (alu_op_i)
      ALU_ADD, ALU_SUB: res_chunk_o = sum[CHUNKSIZE-1:0];
      ALU_XOR:          res_chunk_o = rs1_chunk_i ^ op_b;
      ALU_OR:           res_chunk_o = rs1_chunk_i | op_b;
      ALU_AND:          res_chunk_o = rs1_chunk_i & op_b;
      default:          res_chunk_o = '0;
    endcase
  end

  // --------------------------------------------------------------------------
  // sequencer and store request
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      active_r <= 1'b0;
      cnt_r    <= '0;
      carry_r  <= 1'b0;
      stb_r    <= 1'b0;
    end else begin
      if (insn_start_i) begin
        active_r <= 1'b1;
        cnt_r    <= '0;
      end else if (active_r) begin
        cnt_r   <= cnt_r + 1'b1;
        carry_r <= sum[CHUNKSIZE];
        if (last_chunk) begin
          active_r <= 1'b0;
          // store goes out the cycle after the last chunk
          stb_r    <= is_store_i;
        end
      end
      if (stb_r && dmem_ack_i) begin
        stb_r <= 1'b0;
      end
    end
  end

  // address and data assemble lsb chunk first
  always_ff @(posedge clk_i) begin
    if (active_r) begin
      adr_r <= {res_chunk_o, adr_r[XLEN-1:CHUNKSIZE]};
      dat_r <= {rs2_chunk_i, dat_r[XLEN-1:CHUNKSIZE]};
    end
  end

  assign chunk_idx_o = cnt_r;
  assign imm_shift_o = active_r;
  assign wr_en_o     = active_r && rd_we_i;

  // alu ops finish on the last chunk and stores on the bus ack
  assign insn_done_o = (last_chunk && !is_store_i) || (stb_r && dmem_ack_i);

  // word stores only
  assign dmem_stb_o = stb_r;
  assign dmem_cyc_o = stb_r;
  assign dmem_we_o  = 1'b1;
  assign dmem_be_o  = 4'hF;
  assign dmem_adr_o = {adr_r[XLEN-1:2], 2'b00};
  assign dmem_dat_o = dat_r;

  // request, address and data held until the memory takes it
  a_dmem_stb_hold: assert property (
    @(posedge clk_i) disable iff (!rst_in)
    (dmem_stb_o && !dmem_ack_i) |=>
      (dmem_stb_o && $stable(dmem_adr_o) && $stable(dmem_dat_o))
  );

  // decode keeps rd_we low for stores
  a_no_wb_on_store: assert property (
    @(posedge clk_i) disable iff (!rst_in)
    wr_en_o |-> !is_store_i
  );

endmodule

//--- hdl/fzr_core.sv
// top level of the chunk-serial RV32I core
// fetch/decode produces instructions, the register bank holds operands
// and execute consumes them one chunk per cycle

module fzr_core #(
  parameter int             CHUNKSIZE = 2,
  parameter fzr_pkg::word_t BOOTADR   = 32'h0000_0000
) (
  input  logic           clk_i,
  input  logic           rst_in,

  output logic           imem_stb_o,
  output logic           imem_cyc_o,
  output fzr_pkg::word_t imem_adr_o,
  input  fzr_pkg::word_t imem_dat_i,
  input  logic           imem_ack_i,

  output logic           dmem_stb_o,
  output logic           dmem_cyc_o,
  output logic           dmem_we_o,
  output logic [3:0]     dmem_be_o,
  output fzr_pkg::word_t dmem_adr_o,
  output fzr_pkg::word_t dmem_dat_o,
  input  logic           dmem_ack_i
);

  import fzr_pkg::*;

  localparam int CW = chunk_cnt_w(CHUNKSIZE);

  // decode to execute
  logic                 insn_start;
  logic                 insn_done;
  alu_op_e              alu_op;
  logic                 is_store;
  logic                 rd_we;
  logic [CHUNKSIZE-1:0] imm_chunk;
  logic                 imm_shift;

  // register bank ports
  reg_idx_t             rs1;
  reg_idx_t             rs2;
  reg_idx_t             rd;
  logic [CW-1:0]        chunk_idx;
  logic                 wr_en;
  logic [CHUNKSIZE-1:0] res_chunk;
  logic [CHUNKSIZE-1:0] rs1_chunk;
  logic [CHUNKSIZE-1:0] rs2_chunk;

  fzr_fetch_decode #(
    .CHUNKSIZE ( CHUNKSIZE ),
    .BOOTADR   ( BOOTADR   )
  ) i_fetch_decode (
    .clk_i        ( clk_i      ),
    .rst_in       ( rst_in     ),
    .insn_done_i  ( insn_done  ),
    .imem_dat_i   ( imem_dat_i ),
    .imem_ack_i   ( imem_ack_i ),
    .imem_stb_o   ( imem_stb_o ),
    .imem_cyc_o   ( imem_cyc_o ),
    .imem_adr_o   ( imem_adr_o ),
    .insn_start_o ( insn_start ),
    .alu_op_o     ( alu_op     ),
    .is_store_o   ( is_store   ),
    .rs1_o        ( rs1        ),
    .rs2_o        ( rs2        ),
    .rd_o         ( rd         ),
    .rd_we_o      ( rd_we      ),
    .imm_chunk_o  ( imm_chunk  ),
    .imm_shift_i  ( imm_shift  )
  );

  fzr_regfile #(
    .CHUNKSIZE ( CHUNKSIZE )
  ) i_regfile (
    .clk_i       ( clk_i     ),
    .rst_in      ( rst_in    ),
    .rs1_i       ( rs1       ),
    .rs2_i       ( rs2       ),
    .rd_i        ( rd        ),
    .chunk_idx_i ( chunk_idx ),
    .wr_en_i     ( wr_en     ),
    .res_chunk_i ( res_chunk ),
    .rs1_chunk_o ( rs1_chunk ),
    .rs2_chunk_o ( rs2_chunk )
  );

  fzr_execute #(
    .CHUNKSIZE ( CHUNKSIZE )
  ) i_execute (
    .clk_i        ( clk_i      ),
    .rst_in       ( rst_in     ),
    .insn_start_i ( insn_start ),
    .alu_op_i     ( alu_op     ),
    .is_store_i   ( is_store   ),
    .rd_we_i      ( rd_we      ),
    .rs1_chunk_i  ( rs1_chunk  ),
    .rs2_chunk_i  ( rs2_chunk  ),
    .imm_chunk_i  ( imm_chunk  ),
    .chunk_idx_o  ( chunk_idx  ),
    .wr_en_o      ( wr_en      ),
    .res_chunk_o  ( res_chunk  ),
    .imm_shift_o  ( imm_shift  ),
    .insn_done_o  ( insn_done  ),
    .dmem_ack_i   ( dmem_ack_i ),
    .dmem_stb_o   ( dmem_stb_o ),
    .dmem_cyc_o   ( dmem_cyc_o ),
    .dmem_we_o    ( dmem_we_o  ),
    .dmem_be_o    ( dmem_be_o  ),
    .dmem_adr_o   ( dmem_adr_o ),
    .dmem_dat_o   ( dmem_dat_o )
  );

endmodule

//--- verification/tb_fzr_core.sv
// testbench for the chunk-serial core
// runs a program from the stimulus file through both bus models
// and compares every store against the listed address and data

module tb_fzr_core;

  timeunit 1ns;
  timeprecision 1ps;

  import fzr_pkg::*;

  localparam int    CHUNKSIZE    = 2;
  localparam word_t BOOTADR      = 32'h0000_0100;
  localparam int    RESET_CYCLES = 8;
  localparam int    STIM_WORDS   = 128;
  localparam int    REQ_LIMIT    = 1000;
  localparam int    RUN_LIMIT    = 20000;
  localparam int    SEED         = 67109;

  logic       clk_i;
  logic       rst_in;
  logic       imem_stb_o;
  logic       imem_cyc_o;
  word_t      imem_adr_o;
  word_t      imem_dat_i;
  logic       imem_ack_i;
  logic       dmem_stb_o;
  logic       dmem_cyc_o;
  logic       dmem_we_o;
  logic [3:0] dmem_be_o;
  word_t      dmem_adr_o;
  word_t      dmem_dat_o;
  logic       dmem_ack_i;

  logic [31:0] stim_mem [0:STIM_WORDS-1];
  int          prog_len;
  int          store_cnt;
  int          fetches;
  int          stores_seen;
  word_t       exp_fetch;
  bit          run_done;
  int          err_value;
  int          err_protocol;
  int          err_timeout;

  fzr_core #(
    .CHUNKSIZE ( CHUNKSIZE ),
    .BOOTADR   ( BOOTADR   )
  ) dut_i (
    .clk_i      ( clk_i      ),
    .rst_in     ( rst_in     ),
    .imem_stb_o ( imem_stb_o ),
    .imem_cyc_o ( imem_cyc_o ),
    .imem_adr_o ( imem_adr_o ),
    .imem_dat_i ( imem_dat_i ),
    .imem_ack_i ( imem_ack_i ),
    .dmem_stb_o ( dmem_stb_o ),
    .dmem_cyc_o ( dmem_cyc_o ),
    .dmem_we_o  ( dmem_we_o  ),
    .dmem_be_o  ( dmem_be_o  ),
    .dmem_adr_o ( dmem_adr_o ),
    .dmem_dat_o ( dmem_dat_o ),
    .dmem_ack_i ( dmem_ack_i )
  );

  // 10 ns clock
  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // reporting helpers
  // --------------------------------------------------------------------------

  task automatic report_mismatch(input string name, input word_t got, input word_t exp);
    $display("[FAIL] %0t ns %s: got %08h, expected %08h", $time, name, got, exp);
    err_value++;
  endtask

  task automatic report_protocol(input string msg);
    $display("%0t ns bus protocol error: %s", $time, msg);
    err_protocol++;
  endtask

  // words past the program decode as custom-0, i.e. a no-op,
  // upper bits mix the whole address
  function automatic word_t fill_word(input word_t adr);
    return {adr[31:7] ^ adr[24:0], 7'b0001011};
  endfunction

  // --------------------------------------------------------------------------
  // instruction bus model
  // --------------------------------------------------------------------------

  task automatic wait_imem_req(output bit found);
    int n;
    n = 0;
    found = 1'b0;
    while (!found && !run_done && n < REQ_LIMIT) begin
      @(negedge clk_i);
      n++;
      if (imem_stb_o === 1'b1) found = 1'b1;
    end
    if (!found && !run_done) begin
      $display("timeout: no instruction fetch within %0d cycles", REQ_LIMIT);
      err_timeout++;
    end
  endtask

  task automatic answer_fetch();
    int    delay;
    int    index;
    word_t adr;
    adr = imem_adr_o;
    // each fetch is the previous one plus 4
    if (adr !== exp_fetch) report_mismatch("imem_adr_o", adr, exp_fetch);
    if (imem_cyc_o !== 1'b1) report_protocol("imem_cyc_o low while imem_stb_o is high");
    delay = int'($urandom_range(3, 0));
    repeat (delay) begin
      @(negedge clk_i);
      if (imem_stb_o !== 1'b1) report_protocol("imem_stb_o fell before imem_ack_i");
      if (imem_adr_o !== adr) report_mismatch("imem_adr_o", imem_adr_o, adr);
    end
    index = int'((adr - BOOTADR) >> 2);
    if (index >= 0 && index < prog_len) begin
      imem_dat_i = stim_mem[2 + index];
    end else begin
      imem_dat_i = fill_word(adr);
    end
    imem_ack_i = 1'b1;
    @(negedge clk_i);
    imem_ack_i = 1'b0;
    if (imem_stb_o !== 1'b0) report_protocol("imem_stb_o still high after imem_ack_i");
    exp_fetch = adr + 32'd4;
    fetches++;
  endtask

  task automatic serve_fetches();
    bit found;
    while (!run_done && err_timeout == 0) begin
      wait_imem_req(found);
      if (found) answer_fetch();
    end
  endtask

  // --------------------------------------------------------------------------
  // data bus model
  // --------------------------------------------------------------------------

  task automatic wait_dmem_req(output bit found);
    int n;
    n = 0;
    found = 1'b0;
    while (!found && !run_done && n < REQ_LIMIT) begin
      @(negedge clk_i);
      n++;
      if (dmem_stb_o === 1'b1) found = 1'b1;
    end
    if (!found && !run_done) begin
      $display("timeout: no store request within %0d cycles", REQ_LIMIT);
      err_timeout++;
    end
  endtask

  task automatic answer_store();
    int    delay;
    int    base;
    word_t adr;
    word_t dat;
    adr = dmem_adr_o;
    dat = dmem_dat_o;
    if (stores_seen >= store_cnt) begin
      report_protocol("store request beyond the expected list");
    end else begin
      base = 2 + prog_len + 2 * stores_seen;
      if (adr !== stim_mem[base]) report_mismatch("dmem_adr_o", adr, stim_mem[base]);
      if (dat !== stim_mem[base + 1]) report_mismatch("dmem_dat_o", dat, stim_mem[base + 1]);
    end
    if (dmem_we_o !== 1'b1) report_protocol("dmem_we_o low on a store");
    if (dmem_be_o !== 4'hF) report_protocol("dmem_be_o not all ones on a word store");
    if (dmem_cyc_o !== 1'b1) report_protocol("dmem_cyc_o low while dmem_stb_o is high");
    delay = int'($urandom_range(3, 0));
    repeat (delay) begin
      @(negedge clk_i);
      if (dmem_stb_o !== 1'b1) report_protocol("dmem_stb_o fell before dmem_ack_i");
      if (dmem_adr_o !== adr) report_mismatch("dmem_adr_o", dmem_adr_o, adr);
      if (dmem_dat_o !== dat) report_mismatch("dmem_dat_o", dmem_dat_o, dat);
    end
    dmem_ack_i = 1'b1;
    @(negedge clk_i);
    dmem_ack_i = 1'b0;
    if (dmem_stb_o !== 1'b0) report_protocol("dmem_stb_o still high after dmem_ack_i");
    stores_seen++;
  endtask

  task automatic serve_stores();
    bit found;
    while (!run_done && err_timeout == 0) begin
      wait_dmem_req(found);
      if (found) answer_store();
    end
  endtask

  // --------------------------------------------------------------------------
  // reset and run control
  // --------------------------------------------------------------------------

  task automatic run_program();
    int cycles;
    repeat (RESET_CYCLES) begin
      @(negedge clk_i);
      if (imem_stb_o !== 1'b0) report_protocol("imem_stb_o high during reset");
      if (dmem_stb_o !== 1'b0) report_protocol("dmem_stb_o high during reset");
    end
    rst_in = 1'b1;
    // first fetch goes out one cycle after release
    @(negedge clk_i);
    if (imem_stb_o !== 1'b1) report_protocol("no fetch in the first cycle after reset");
    if (imem_adr_o !== BOOTADR) report_mismatch("imem_adr_o", imem_adr_o, BOOTADR);
    // a few fill words past the program check pc steps after the last store
    cycles = 0;
    while ((stores_seen < store_cnt || fetches < prog_len + 4) && err_timeout == 0
           && cycles < RUN_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (cycles >= RUN_LIMIT) begin
      $display("timeout: program did not finish within %0d cycles", RUN_LIMIT);
      err_timeout++;
    end
    run_done = 1'b1;
  endtask

  initial begin
    rst_in       = 1'b0;
    imem_dat_i   = '0;
    imem_ack_i   = 1'b0;
    dmem_ack_i   = 1'b0;
    fetches      = 0;
    stores_seen  = 0;
    exp_fetch    = BOOTADR;
    run_done     = 1'b0;
    err_value    = 0;
    err_protocol = 0;
    err_timeout  = 0;
    void'($urandom(SEED));
    for (int i = 0; i < STIM_WORDS; i++) begin
      stim_mem[i] = '0;
    end
    $readmemh("verification/fzr_program_stimulus.txt", stim_mem);
    prog_len  = int'(stim_mem[0]);
    store_cnt = int'(stim_mem[1]);
    if (prog_len == 0 || 2 + prog_len + 2 * store_cnt > STIM_WORDS) begin
      report_protocol("stimulus file is missing, empty or too long");
    end

    fork
      serve_fetches();
      serve_stores();
      run_program();
    join

    $display("errors: %0d value, %0d protocol, %0d timeout, %0d of %0d stores seen",
             err_value, err_protocol, err_timeout, stores_seen, store_cnt);
    if (err_value == 0 && err_protocol == 0 && err_timeout == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- verilog.f
common/fzr_pkg.sv
hdl/fzr_fetch_decode.sv
hdl/fzr_regfile.sv
hdl/fzr_execute.sv
hdl/fzr_core.sv
verification/tb_fzr_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile the core testbench with verilator, run it and check the log
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_fzr_core
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f verilog.f --top-module "$TOP" --Mdir "$BUILD_DIR" -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- verification/fzr_program_stimulus.txt
// program image and expected stores for the core testbench, one hex word per entry
// word 0 = program length, word 1 = store count, then the program words,
// then one line per expected store with the address and the data word
00000023 // 35 program words
0000000D // 13 stores
FFF00093 // addi x1, x0, -1
7FF00113 // addi x2, x0, 0x7ff
12300293 // addi x5, x0, 0x123
5550C193 // xori x3, x1, 0x555
F002E213 // ori  x4, x5, -256
0F01F313 // andi x6, x3, 0x0f0
FF80F393 // andi x7, x1, -8
7FF10413 // addi x8, x2, 0x7ff
20302023 // sw x3, 0x200(x0)
20402223 // sw x4, 0x204(x0)
20602423 // sw x6, 0x208(x0)
20702623 // sw x7, 0x20c(x0)
20802823 // sw x8, 0x210(x0)
005084B3 // add x9, x1, x5 (wraps)
40228533 // sub x10, x5, x2 (borrows)
401005B3 // sub x11, x0, x1
0041C633 // xor x12, x3, x4
005366B3 // or  x13, x6, x5
0071F733 // and x14, x3, x7
009484B3 // add x9, x9, x9 (rd is also both sources)
20902A23 // sw x9, 0x214(x0)
20A02C23 // sw x10, 0x218(x0)
20B02E23 // sw x11, 0x21c(x0)
00C123A3 // sw x12, 7(x2), unaligned sum
FED12823 // sw x13, -16(x2), unaligned sum
22E02023 // sw x14, 0x220(x0)
00508013 // addi x0, x1, 5
00108033 // add x0, x1, x1
ABCDE2B7 // lui x5, 0xabcde, not decoded here
0020A2B3 // slt x5, x1, x2, not decoded here
0010A293 // slti x5, x1, 1, not decoded here
00002283 // lw x5, 0(x0), not decoded here
0000028B // custom-0 with rd x5
22002223 // sw x0, 0x224(x0)
22502423 // sw x5, 0x228(x0)
00000200 FFFFFAAA
00000204 FFFFFF23
00000208 000000A0
0000020C FFFFFFF8
00000210 00000FFE
00000214 00000244
00000218 FFFFF924
0000021C 00000001
00000804 00000589
000007EC 000001A3
00000220 FFFFFAA8
00000224 00000000
00000228 00000123
